/* source/dcache_cfg_pkg.sv */
package dcache_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////////////////////////
  localparam int ADDR_W     = 32;  // physical byte address
  localparam int LINE_OFS_W = 6;   // 64 byte lines
  localparam int DEF_SETS   = 64;
  localparam int DEF_WAYS   = 8;

  //////////////////////////////////////////////////////////////////////
  // APB register map, byte offsets
  //////////////////////////////////////////////////////////////////////
  localparam logic [7:0] REG_ADDR    = 8'h00;
  localparam logic [7:0] REG_CMD     = 8'h04;  // [1:0] opcode, [2] excl
  localparam logic [7:0] REG_VICTIM  = 8'h08;  // [7:0] primary, [15:8] alternate
  localparam logic [7:0] REG_STATUS  = 8'h0C;
  localparam logic [7:0] REG_WB_ADDR = 8'h10;

endpackage

/* source/dcache_tag_pkg.sv */
package dcache_tag_pkg;

  import dcache_cfg_pkg::*;

  // tag bits left over once offset and index are taken
  localparam int ENTRY_TAG_W = ADDR_W - LINE_OFS_W - $clog2(DEF_SETS);

  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_FILL   = 2'd1,
    OP_INVAL  = 2'd2  // 3 is rejected by the front
  } tag_op_e;

  typedef struct packed {
    logic                   valid;
    logic                   recent;  // set on lookup hit, cleared on fill
    logic                   excl;
    logic [ENTRY_TAG_W-1:0] tag;
  } tag_entry_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,  // cmd accepted, sweep still running
    WAIT  = 2'd2
  } front_state_e;

endpackage

/* source/tag_if.sv */
`timescale 1ns/10ps

interface tag_req_if
  import dcache_cfg_pkg::*, dcache_tag_pkg::*;
#(
  parameter int SETS = DEF_SETS,
  parameter int WAYS = DEF_WAYS
);
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - LINE_OFS_W - IDX_W;
  localparam int WAY_W = $clog2(WAYS);

  logic             valid;  // one cycle pulse
  tag_op_e          op;
  logic [IDX_W-1:0] index;
  logic [TAG_W-1:0] tag;
  logic             excl;
  logic [WAY_W-1:0] victim_pri;
  logic [WAY_W-1:0] victim_alt;

  modport src (output valid, op, index, tag, excl, victim_pri, victim_alt);
  modport dst (input valid, op, index, tag, excl, victim_pri, victim_alt);
endinterface

interface tag_wr_if
  import dcache_cfg_pkg::*, dcache_tag_pkg::*;
#(
  parameter int SETS = DEF_SETS,
  parameter int WAYS = DEF_WAYS
);
  logic [WAYS-1:0]         wen;
  logic [$clog2(SETS)-1:0] index;
  tag_entry_t              entry;

  modport src (output wen, index, entry);
  modport dst (input wen, index, entry);
endinterface

interface tag_rsp_if
  import dcache_cfg_pkg::*;
#(
  parameter int WAYS = DEF_WAYS
);
  logic                    done;
  logic                    hit;
  logic [$clog2(WAYS)-1:0] way;
  logic                    excl;
  logic                    wb_valid;
  logic [ADDR_W-1:0]       wb_addr;

  modport src (output done, hit, way, excl, wb_valid, wb_addr);
  modport dst (input done, hit, way, excl, wb_valid, wb_addr);
endinterface

/* source/tag_ram.sv */
`timescale 1ns/10ps

module tag_ram #(
  parameter int SETS    = 64,
  parameter int ENTRY_W = 23
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    read_en,
  input  logic [$clog2(SETS)-1:0] read_addr,
  output logic [ENTRY_W-1:0]      read_data,
  input  logic [$clog2(SETS)-1:0] write_addr,
  input  logic [ENTRY_W-1:0]      write_data,
  input  logic                    write_en
);
  localparam int IDX_W = $clog2(SETS);

  logic [ENTRY_W-1:0] ram [SETS];
  logic [IDX_W-1:0]   read_addr_reg;

  // array read after the address register gives write first
  assign read_data = ram[read_addr_reg];

  always_ff @(posedge clk) begin
    if (rst) read_addr_reg <= '0;
    else if (read_en) read_addr_reg <= read_addr;
  end

  always_ff @(posedge clk) begin
    if (write_en) ram[write_addr] <= write_data;
  end

  a_waddr_range: assert property (@(posedge clk) disable iff (rst)
    write_en |-> (32'(write_addr) < SETS))
    else $error("tag_ram write beyond last set");

endmodule

/* source/tag_array.sv */
`timescale 1ns/10ps

module tag_array
  import dcache_cfg_pkg::*, dcache_tag_pkg::*;
#(
  parameter int SETS = DEF_SETS,
  parameter int WAYS = DEF_WAYS
) (
  input  logic                  clk,
  input  logic                  rst,
  tag_req_if.dst                req,
  tag_req_if.src                req_out,
  tag_wr_if.dst                 wr,
  output logic                  init_busy,
  output logic [WAYS-1:0]       hit_vec,
  output tag_entry_t [WAYS-1:0] ways
);
  localparam int IDX_W   = $clog2(SETS);
  localparam int ENTRY_W = $bits(tag_entry_t);

  logic [IDX_W-1:0]   init_cnt;
  logic [IDX_W-1:0]   ram_waddr;
  logic [ENTRY_W-1:0] ram_wdata;

  //////////////////////////////////////////////////////////////////////
  // reset sweep, one set per cycle
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      init_cnt  <= '0;
    end else if (init_busy) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == IDX_W'(SETS - 1)) init_busy <= 1'b0;
    end
  end

  assign ram_waddr = init_busy ? init_cnt : wr.index;
  assign ram_wdata = init_busy ? '0 : wr.entry;  // sweep writes empty entries

  //////////////////////////////////////////////////////////////////////
  // ways and compare
  //////////////////////////////////////////////////////////////////////
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    tag_ram #(
      .SETS    (SETS),
      .ENTRY_W (ENTRY_W)
    ) u_ram (
      .clk        (clk),
      .rst        (rst),
      .read_en    (req.valid),
      .read_addr  (req.index),
      .read_data  (ways[w]),
      .write_addr (ram_waddr),
      .write_data (ram_wdata),
      .write_en   (init_busy || wr.wen[w])
    );

    assign hit_vec[w] = ways[w].valid && (ways[w].tag == req_out.tag);
  end

  // request follows the ram read by one stage
  always_ff @(posedge clk) begin
    if (rst) req_out.valid <= 1'b0;
    else req_out.valid <= req.valid;
  end

  always_ff @(posedge clk) begin
    if (req.valid) begin
      req_out.op         <= req.op;
      req_out.index      <= req.index;
      req_out.tag        <= req.tag;
      req_out.excl       <= req.excl;
      req_out.victim_pri <= req.victim_pri;
      req_out.victim_alt <= req.victim_alt;
    end
  end

  a_no_req_in_sweep: assert property (@(posedge clk) disable iff (rst)
    req.valid |-> !init_busy)
    else $error("request issued during reset sweep");

endmodule

/* source/tag_resolve.sv */
`timescale 1ns/10ps

module tag_resolve
  import dcache_cfg_pkg::*, dcache_tag_pkg::*;
#(
  parameter int SETS = DEF_SETS,
  parameter int WAYS = DEF_WAYS
) (
  input  logic                  clk,
  input  logic                  rst,
  tag_req_if.dst                req,
  input  logic [WAYS-1:0]       hit_vec,
  input  tag_entry_t [WAYS-1:0] ways,
  tag_wr_if.src                 wr,
  tag_rsp_if.src                rsp
);
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - LINE_OFS_W - IDX_W;
  localparam int WAY_W = $clog2(WAYS);

  logic              any_hit;
  logic [WAY_W-1:0]  hit_way;
  logic              any_free;
  logic [WAY_W-1:0]  free_way;
  logic [WAY_W-1:0]  victim;
  logic              fill_miss;
  logic              do_write;
  logic [WAY_W-1:0]  sel_way;
  logic              wb_valid;
  logic [ADDR_W-1:0] wb_addr;
  tag_entry_t        new_entry;

  always_comb begin
    any_hit  = 1'b0;
    hit_way  = '0;
    any_free = 1'b0;
    free_way = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin  // lowest way wins
      if (hit_vec[w]) begin
        any_hit = 1'b1;
        hit_way = WAY_W'(w);
      end
      if (!ways[w].valid) begin
        any_free = 1'b1;
        free_way = WAY_W'(w);
      end
    end
  end

  always_comb begin
    if (any_free) victim = free_way;
    else if (ways[req.victim_pri].recent) victim = req.victim_alt;
    else victim = req.victim_pri;
  end

  assign fill_miss = (req.op == OP_FILL) && !any_hit;
  assign sel_way   = fill_miss ? victim : hit_way;
  assign wb_valid  = fill_miss && ways[victim].valid;

  always_comb begin
    new_entry = ways[hit_way];
    do_write  = any_hit;
    case (req.op)
      OP_LOOKUP: new_entry.recent = 1'b1;
      OP_FILL: begin
        new_entry.excl = req.excl;
        if (!any_hit) begin  // fresh line in the victim way
          new_entry.valid  = 1'b1;
          new_entry.recent = 1'b0;
          new_entry.tag    = req.tag;
          do_write         = 1'b1;
        end
      end
      OP_INVAL: new_entry.valid = 1'b0;
      default: do_write = 1'b0;
    endcase
  end

  always_comb begin
    wb_addr = '0;
    if (wb_valid) begin
      wb_addr[ADDR_W-1 -: TAG_W]   = ways[victim].tag;
      wb_addr[LINE_OFS_W +: IDX_W] = req.index;
    end
  end

  assign wr.wen   = (req.valid && do_write) ? (WAYS'(1) << sel_way) : '0;
  assign wr.index = req.index;
  assign wr.entry = new_entry;

  always_ff @(posedge clk) begin
    if (rst) rsp.done <= 1'b0;
    else rsp.done <= req.valid;
  end

  always_ff @(posedge clk) begin
    if (req.valid) begin
      rsp.hit      <= any_hit;
      rsp.way      <= sel_way;
      rsp.excl     <= any_hit && ways[hit_way].excl;  // before update
      rsp.wb_valid <= wb_valid;
      rsp.wb_addr  <= wb_addr;
    end
  end

  // a tag lives in at most one way of a set
  a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
    req.valid |-> $onehot0(hit_vec))
    else $error("tag resident in more than one way");

endmodule

/* source/tag_apb_front.sv */
`timescale 1ns/10ps

module tag_apb_front
  import dcache_cfg_pkg::*, dcache_tag_pkg::*;
#(
  parameter int SETS = DEF_SETS
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        init_busy,
  tag_req_if.src      req,
  tag_rsp_if.dst      rsp
);
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - LINE_OFS_W - IDX_W;
  localparam int WAY_W = $bits(req.victim_pri);

  front_state_e      state;
  logic [ADDR_W-1:0] addr_q;
  tag_op_e           op_q;
  logic              excl_q;
  logic [WAY_W-1:0]  vpri_q;
  logic [WAY_W-1:0]  valt_q;
  logic              st_hit;
  logic              st_excl;
  logic              st_wb_valid;
  logic [WAY_W-1:0]  st_way;
  logic [ADDR_W-1:0] st_wb_addr;
  logic              setup;
  logic              mapped;
  logic              cmd_wr;
  logic              err;
  logic [31:0]       rd_mux;

  assign setup  = psel && !penable && (state == IDLE);
  assign cmd_wr = pwrite && (paddr == REG_CMD);
  assign err    = !mapped || (cmd_wr && pwdata[1:0] == 2'd3);  // opcode 3 illegal

  always_comb begin
    mapped = 1'b1;
    rd_mux = '0;
    case (paddr)
      REG_ADDR:    rd_mux = addr_q;
      REG_CMD:     rd_mux = {29'd0, excl_q, op_q};
      REG_VICTIM: begin
        rd_mux[WAY_W-1:0]  = vpri_q;
        rd_mux[8 +: WAY_W] = valt_q;
      end
      REG_STATUS: begin
        rd_mux[3:0]        = {init_busy, st_wb_valid, st_excl, st_hit};
        rd_mux[8 +: WAY_W] = st_way;
      end
      REG_WB_ADDR: rd_mux = st_wb_addr;
      default:     mapped = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // command FSM and APB handshake
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      pready    <= 1'b0;
      pslverr   <= 1'b0;
      req.valid <= 1'b0;
    end else begin
      pready    <= 1'b0;
      pslverr   <= 1'b0;
      req.valid <= 1'b0;
      case (state)
        IDLE: if (setup) begin
          if (cmd_wr && !err) begin
            if (init_busy) begin
              state <= ISSUE;  // hold until sweep done
            end else begin
              req.valid <= 1'b1;
              state     <= WAIT;
            end
          end else begin
            pready  <= 1'b1;  // single access cycle
            pslverr <= err;
          end
        end
        ISSUE: if (!init_busy) begin
          req.valid <= 1'b1;
          state     <= WAIT;
        end
        WAIT: if (rsp.done) begin
          pready <= 1'b1;
          state  <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q      <= '0;
      op_q        <= OP_LOOKUP;
      excl_q      <= 1'b0;
      vpri_q      <= '0;
      valt_q      <= '0;
      st_hit      <= 1'b0;
      st_excl     <= 1'b0;
      st_wb_valid <= 1'b0;
      st_way      <= '0;
      st_wb_addr  <= '0;
    end else begin
      if (setup && pwrite && !err) begin
        if (paddr == REG_ADDR) addr_q <= pwdata[ADDR_W-1:0];
        if (paddr == REG_VICTIM) begin
          vpri_q <= pwdata[WAY_W-1:0];
          valt_q <= pwdata[8 +: WAY_W];
        end
        if (cmd_wr) begin
          op_q   <= tag_op_e'(pwdata[1:0]);
          excl_q <= pwdata[2];
        end
      end
      if (rsp.done) begin
        st_hit      <= rsp.hit;
        st_excl     <= rsp.excl;
        st_wb_valid <= rsp.wb_valid;
        st_way      <= rsp.way;
        st_wb_addr  <= rsp.wb_addr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (setup) prdata <= rd_mux;
  end

  assign req.op         = op_q;
  assign req.index      = addr_q[LINE_OFS_W +: IDX_W];
  assign req.tag        = addr_q[ADDR_W-1 -: TAG_W];
  assign req.excl       = excl_q;
  assign req.victim_pri = vpri_q;
  assign req.victim_alt = valt_q;

endmodule

/* source/dcache_tag_top.sv */
`timescale 1ns/10ps

module dcache_tag_top
  import dcache_cfg_pkg::*, dcache_tag_pkg::*;
#(
  parameter int SETS = DEF_SETS,
  parameter int WAYS = DEF_WAYS
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  logic                  init_busy;
  logic [WAYS-1:0]       hit_vec;
  tag_entry_t [WAYS-1:0] ways;

  tag_req_if #(.SETS(SETS), .WAYS(WAYS)) req_issue ();  // front to array
  tag_req_if #(.SETS(SETS), .WAYS(WAYS)) req_cmp ();    // array to resolve
  tag_wr_if  #(.SETS(SETS), .WAYS(WAYS)) wr_bus ();
  tag_rsp_if #(.WAYS(WAYS))              rsp_bus ();

  tag_apb_front #(.SETS(SETS)) u_front (
    .clk       (clk),
    .rst       (rst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .init_busy (init_busy),
    .req       (req_issue.src),
    .rsp       (rsp_bus.dst)
  );

  tag_array #(.SETS(SETS), .WAYS(WAYS)) u_array (
    .clk       (clk),
    .rst       (rst),
    .req       (req_issue.dst),
    .req_out   (req_cmp.src),
    .wr        (wr_bus.dst),
    .init_busy (init_busy),
    .hit_vec   (hit_vec),
    .ways      (ways)
  );

  tag_resolve #(.SETS(SETS), .WAYS(WAYS)) u_resolve (
    .clk     (clk),
    .rst     (rst),
    .req     (req_cmp.dst),
    .hit_vec (hit_vec),
    .ways    (ways),
    .wr      (wr_bus.src),
    .rsp     (rsp_bus.src)
  );

endmodule

/* tests/tb_dcache_tag.sv */
`timescale 1ns/10ps

module tb_dcache_tag
  import dcache_cfg_pkg::*;
();
  localparam int    SETS      = DEF_SETS;
  localparam int    WAYS      = DEF_WAYS;
  localparam int    WAY_W     = $clog2(WAYS);
  localparam int    MAX_CASES = 64;
  localparam string CASE_FILE = "tests/dcache_tag_cases.txt";

  logic        clk = 1'b0;
  logic        rst;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] c_op [MAX_CASES];
  logic [31:0] c_addr [MAX_CASES];
  logic [31:0] c_excl [MAX_CASES];
  logic [31:0] c_vpri [MAX_CASES];
  logic [31:0] c_valt [MAX_CASES];
  logic [31:0] e_hit [MAX_CASES];
  logic [31:0] e_way [MAX_CASES];
  logic [31:0] e_excl [MAX_CASES];
  logic [31:0] e_wbv [MAX_CASES];
  logic [31:0] e_wbaddr [MAX_CASES];

  int   n_cases   = 0;
  int   cur_test  = 0;
  int   errors    = 0;
  int   tests_run = 0;
  int   tests_ok  = 0;
  logic started   = 1'b0;

  always #10 clk = ~clk;

  dcache_tag_top #(.SETS(SETS), .WAYS(WAYS)) i_dut (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  //////////////////////////////////////////////////////////////////////
  // APB master and checks
  //////////////////////////////////////////////////////////////////////
  task automatic apb_access(input logic is_wr, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    logic stretch;
    stretch = is_wr && (addr == REG_CMD) && (wdata[1:0] != 2'd3);  // legal cmd waits for done
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= is_wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    check_value("pready", 32'(pready), 32'(!stretch));
    while (!pready) @(negedge clk);  // cmd writes stretch here
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input int i);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, REG_STATUS, 32'd0, rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    check_value("status.hit", 32'(rdata[0]), e_hit[i]);
    check_value("status.excl", 32'(rdata[1]), e_excl[i]);
    check_value("status.wb_valid", 32'(rdata[2]), e_wbv[i]);
    check_value("status.init_busy", 32'(rdata[3]), 32'd0);
    check_value("status.way", 32'(rdata[8 +: WAY_W]), e_way[i]);
    apb_access(1'b0, REG_WB_ADDR, 32'd0, rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    check_value("wb_addr", rdata, e_wbaddr[i]);
  endtask

  task automatic finish_test(input string what, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      tests_ok++;
      $display("test %0d %s: ok", cur_test, what);
    end else begin
      $display("test %0d %s: mismatch", cur_test, what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // case file and replay
  //////////////////////////////////////////////////////////////////////
  task automatic load_cases();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f [10];
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("cannot open case file %s", CASE_FILE);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#" && n_cases < MAX_CASES) begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                           f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
          if (fields == 10) begin
            c_op[n_cases]     = f[0];
            c_addr[n_cases]   = f[1];
            c_excl[n_cases]   = f[2];
            c_vpri[n_cases]   = f[3];
            c_valt[n_cases]   = f[4];
            e_hit[n_cases]    = f[5];
            e_way[n_cases]    = f[6];
            e_excl[n_cases]   = f[7];
            e_wbv[n_cases]    = f[8];
            e_wbaddr[n_cases] = f[9];
            n_cases++;
          end
        end
      end
      $fclose(fd);
      if (n_cases == 0) begin
        $display("case file holds no usable lines");
        errors++;
      end
    end
  endtask

  task automatic run_case(input int i);
    logic [31:0] rdata;
    logic        err;
    int          errs_at_start;
    errs_at_start = errors;
    cur_test      = i + 1;
    apb_access(1'b1, REG_VICTIM, {16'd0, c_valt[i][7:0], c_vpri[i][7:0]}, rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    apb_access(1'b1, REG_ADDR, c_addr[i], rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    apb_access(1'b1, REG_CMD, {29'd0, c_excl[i][0], c_op[i][1:0]}, rdata, err);
    check_value("pslverr", 32'(err), 32'(c_op[i] == 32'd3));  // opcode 3 rejected
    check_status(i);
    finish_test($sformatf("op %0d addr 0x%08h", c_op[i], c_addr[i]), errs_at_start);
    repeat ($urandom % 4) @(posedge clk);
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          errs_at_start;
    rst     <= 1'b1;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    void'($urandom(32'hce95));
    load_cases();
    repeat (16) @(posedge clk);
    rst     <= 1'b0;
    started = 1'b1;
    if (n_cases > 0) begin
      errs_at_start = errors;
      apb_access(1'b0, REG_STATUS, 32'd0, rdata, err);
      check_value("status.init_busy", 32'(rdata[3]), 32'd1);  // sweep still running
      finish_test("sweep busy after reset", errs_at_start);
      for (int i = 0; i < n_cases; i++) run_case(i);
      // unmapped offsets leave status alone
      cur_test      = n_cases + 1;
      errs_at_start = errors;
      apb_access(1'b1, 8'h14, 32'hffff_ffff, rdata, err);
      check_value("pslverr", 32'(err), 32'd1);
      apb_access(1'b0, 8'h18, 32'd0, rdata, err);
      check_value("pslverr", 32'(err), 32'd1);
      check_status(n_cases - 1);
      finish_test("unmapped offsets", errs_at_start);
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_ok,
             tests_run - tests_ok, errors);
    if (errors == 0 && tests_ok == tests_run) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    wait (started);
    repeat (SETS + 40 * (n_cases + 1)) @(posedge clk);
    $display("timeout: test %0d did not complete", cur_test);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* dcache_tag.f */
source/dcache_cfg_pkg.sv
source/dcache_tag_pkg.sv
source/tag_if.sv
source/tag_ram.sv
source/tag_array.sv
source/tag_resolve.sv
source/tag_apb_front.sv
source/dcache_tag_top.sv
tests/tb_dcache_tag.sv

/* Makefile */
# Verilator build and run for the dcache_tag testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache_tag
FILELIST  ?= dcache_tag.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: run build lint clean

run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tests/dcache_tag_cases.txt */
# op addr excl victim_pri victim_alt | expected hit way excl wb_valid wb_addr, all hex
# op 0 lookup, 1 fill, 2 inval, 3 illegal (status must repeat the line before)
0 00001140 0 0 0  0 0 0 0 00000000
0 deadbf80 0 0 0  0 0 0 0 00000000
1 00001140 1 0 0  0 0 0 0 00000000
0 00001140 0 0 0  1 0 1 0 00000000
0 00002140 0 0 0  0 0 0 0 00000000
1 00002140 0 0 0  0 1 0 0 00000000
1 00003140 0 0 0  0 2 0 0 00000000
1 00004140 0 0 0  0 3 0 0 00000000
1 00005140 0 0 0  0 4 0 0 00000000
1 00006140 0 0 0  0 5 0 0 00000000
1 00007140 0 0 0  0 6 0 0 00000000
1 00008140 0 0 0  0 7 0 0 00000000
1 00009140 0 3 6  0 3 0 1 00004140
1 0000a140 0 0 5  0 5 0 1 00006140
1 00002140 1 0 0  1 1 0 0 00000000
0 00002140 0 0 0  1 1 1 0 00000000
3 00002140 0 0 0  1 1 1 0 00000000
2 00007140 0 0 0  1 6 0 0 00000000
0 00007140 0 0 0  0 0 0 0 00000000
1 0000b140 0 0 1  0 6 0 0 00000000
0 0000b140 0 0 0  1 6 0 0 00000000
2 0000c140 0 0 0  0 0 0 0 00000000
